/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module vga_top_tb -o vga_sim
	out="$$(./obj_dir/vga_sim)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* block_ctl.sv */
// ----------------------------------------------------------------------
// block_ctl
// moves and rotates the piece from the buttons, lands it on a blocked
// down move and spawns the next shape at the top
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module block_ctl #(
  parameter int grid_cols = 10,
  parameter int grid_rows = 18
) (
  input  logic                       pclk,
  input  logic                       reset,
  input  logic                       btn_left,
  input  logic                       btn_right,
  input  logic                       btn_down,
  input  logic                       btn_up,
  output logic [vga_pkg::cell_w-1:0] xpos,
  output logic [vga_pkg::cell_w-1:0] ypos,
  output vga_pkg::shape_t            shape,
  output vga_pkg::rot_t              rot
);
  import vga_pkg::*;

  localparam logic [cell_w-1:0] spawn_x = cell_w'(grid_cols / 2 - 2);

  // bit order up, down, right, left
  logic [3:0]      btn_s1;
  logic [3:0]      btn_s2;
  logic [3:0]      btn_s3;
  logic [3:0]      rise;
  logic [cell_w:0] cand_x;
  logic [cell_w:0] cand_y;
  rot_t            cand_rot;
  cells_t          cand_cells;
  logic            is_down;
  logic            fits;
  logic [cell_w+1:0] cx;
  logic [cell_w+1:0] cy;

  always_ff @(posedge pclk) begin
    if (reset) begin
      btn_s1 <= '0;
      btn_s2 <= '0;
      btn_s3 <= '0;
    end else begin
      btn_s1 <= {btn_up, btn_down, btn_right, btn_left};
      btn_s2 <= btn_s1;
      btn_s3 <= btn_s2;
    end
  end

  assign rise = btn_s2 & ~btn_s3;

  // one candidate per cycle, left wins over right, down, up
  always_comb begin
    cand_x   = {1'b0, xpos};
    cand_y   = {1'b0, ypos};
    cand_rot = rot;
    is_down  = 1'b0;
    if (rise[0]) begin
      cand_x = {1'b0, xpos} - 1'b1;
    end else if (rise[1]) begin
      cand_x = {1'b0, xpos} + 1'b1;
    end else if (rise[2]) begin
      cand_y  = {1'b0, ypos} + 1'b1;
      is_down = 1'b1;
    end else if (rise[3]) begin
      cand_rot = rot + 1'b1;
    end
  end

  assign cand_cells = block_cells(shape, cand_rot);

  // origin underflow wraps high and fails the bound check
  always_comb begin
    fits = 1'b1;
    cx   = '0;
    cy   = '0;
    for (int i = 0; i < 4; i++) begin
      cx = {1'b0, cand_x} + {{cell_w{1'b0}}, cand_cells.col[i]};
      cy = {1'b0, cand_y} + {{cell_w{1'b0}}, cand_cells.row[i]};
      if (cx >= grid_cols || cy >= grid_rows)
        fits = 1'b0;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      xpos  <= spawn_x;
      ypos  <= '0;
      shape <= shape_i;
      rot   <= '0;
    end else if (|rise) begin
      if (fits) begin
        xpos <= cand_x[cell_w-1:0];
        ypos <= cand_y[cell_w-1:0];
        rot  <= cand_rot;
      end else if (is_down) begin
        // landed, next shape from the top
        xpos  <= spawn_x;
        ypos  <= '0;
        rot   <= '0;
        shape <= (shape == shape_l) ? shape_i : shape + 1'b1;
      end
    end
  end

endmodule

/* draw_background.sv */
// ----------------------------------------------------------------------
// draw_background
// paints the playing grid and the margin, black during blanking
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module draw_background #(
  parameter int h_active  = 800,
  parameter int v_active  = 600,
  parameter int cell_px   = 32,
  parameter int grid_cols = 10,
  parameter int grid_rows = 18
) (
  input  logic      pclk,
  input  logic      reset,
  vga_bus_if.snk    vin,
  vga_bus_if.src    vout
);
  import vga_pkg::*;

  // grid never extends past the visible area
  localparam int grid_w = (grid_cols * cell_px < h_active) ? grid_cols * cell_px : h_active;
  localparam int grid_h = (grid_rows * cell_px < v_active) ? grid_rows * cell_px : v_active;

  logic in_grid;

  assign in_grid = (vin.hcount < cnt_w'(grid_w)) && (vin.vcount < cnt_w'(grid_h));

  always_ff @(posedge pclk) begin
    if (reset) begin
      vout.hcount <= '0;
      vout.vcount <= '0;
      vout.hsync  <= 1'b0;
      vout.vsync  <= 1'b0;
      vout.hblnk  <= 1'b0;
      vout.vblnk  <= 1'b0;
      vout.rgb    <= '0;
    end else begin
      vout.hcount <= vin.hcount;
      vout.vcount <= vin.vcount;
      vout.hsync  <= vin.hsync;
      vout.vsync  <= vin.vsync;
      vout.hblnk  <= vin.hblnk;
      vout.vblnk  <= vin.vblnk;
      if (vin.hblnk || vin.vblnk)
        vout.rgb <= '0;
      else
        vout.rgb <= in_grid ? colour_field : colour_margin;
    end
  end

endmodule

/* draw_block.sv */
// ----------------------------------------------------------------------
// draw_block
// overlays the four cells of the current piece onto the picture
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module draw_block #(
  parameter int cell_px = 32
) (
  input  logic                       pclk,
  input  logic                       reset,
  vga_bus_if.snk                     vin,
  vga_bus_if.src                     vout,
  input  logic [vga_pkg::cell_w-1:0] xpos,
  input  logic [vga_pkg::cell_w-1:0] ypos,
  input  vga_pkg::shape_t            shape,
  input  vga_pkg::rot_t              rot
);
  import vga_pkg::*;

  // cell_px is a power of two, so a shift gives the cell index
  localparam int cell_sh = $clog2(cell_px);

  cells_t           cells;
  logic [cnt_w-1:0] px_col;
  logic [cnt_w-1:0] px_row;
  logic [cnt_w-1:0] org_col;
  logic [cnt_w-1:0] org_row;
  logic             hit;

  assign cells   = block_cells(shape, rot);
  assign px_col  = vin.hcount >> cell_sh;
  assign px_row  = vin.vcount >> cell_sh;
  assign org_col = {{(cnt_w - cell_w){1'b0}}, xpos};
  assign org_row = {{(cnt_w - cell_w){1'b0}}, ypos};

  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (px_col == org_col + {{(cnt_w - 2){1'b0}}, cells.col[i]} &&
          px_row == org_row + {{(cnt_w - 2){1'b0}}, cells.row[i]})
        hit = 1'b1;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      vout.hcount <= '0;
      vout.vcount <= '0;
      vout.hsync  <= 1'b0;
      vout.vsync  <= 1'b0;
      vout.hblnk  <= 1'b0;
      vout.vblnk  <= 1'b0;
      vout.rgb    <= '0;
    end else begin
      vout.hcount <= vin.hcount;
      vout.vcount <= vin.vcount;
      vout.hsync  <= vin.hsync;
      vout.vsync  <= vin.vsync;
      vout.hblnk  <= vin.hblnk;
      vout.vblnk  <= vin.vblnk;
      // piece only shows in active video
      if (hit && !vin.hblnk && !vin.vblnk)
        vout.rgb <= shape_colour(shape);
      else
        vout.rgb <= vin.rgb;
    end
  end

endmodule

/* project.f */
vga_pkg.sv
vga_bus_if.sv
vga_timing.sv
draw_background.sv
draw_block.sv
block_ctl.sv
vga_top.sv
tb_clock.sv
vga_top_chk.sv
vga_top_tb.sv

/* tb_clock.sv */
// ----------------------------------------------------------------------
// tb_clock
// testbench clock and synchronous reset generator
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock #(
  parameter int period       = 100,
  parameter int reset_cycles = 2
) (
  output logic pclk,
  output logic reset
);

  initial begin
    pclk = 1'b0;
    forever #(period / 2) pclk = ~pclk;
  end

  // reset drops on a rising edge after reset_cycles edges
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge pclk);
    reset <= 1'b0;
  end

endmodule

/* vga_bus_if.sv */
// ----------------------------------------------------------------------
// vga_bus_if
// counters, syncs, blanks and colour passed between pixel stages
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface vga_bus_if;
  import vga_pkg::*;

  logic [cnt_w-1:0] hcount;
  logic [cnt_w-1:0] vcount;
  logic             hsync;
  logic             vsync;
  logic             hblnk;
  logic             vblnk;
  rgb_t             rgb;

  modport src (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  modport snk (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

/* vga_pkg.sv */
// ----------------------------------------------------------------------
// vga_pkg
// shared types, widths, colours and the piece shape table for the
// falling-block display
// ----------------------------------------------------------------------
package vga_pkg;

  localparam int cnt_w  = 11;
  localparam int cell_w = 5;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef logic [2:0] shape_t;
  typedef logic [1:0] rot_t;

  // four cells of a piece, offsets from its origin
  typedef struct packed {
    logic [3:0][1:0] col;
    logic [3:0][1:0] row;
  } cells_t;

  localparam shape_t shape_i = 3'd0;
  localparam shape_t shape_o = 3'd1;
  localparam shape_t shape_t_ = 3'd2;
  localparam shape_t shape_s = 3'd3;
  localparam shape_t shape_z = 3'd4;
  localparam shape_t shape_j = 3'd5;
  localparam shape_t shape_l = 3'd6;

  localparam rgb_t colour_margin = '{r: 4'h8, g: 4'h8, b: 4'h8};
  localparam rgb_t colour_field  = '{r: 4'h0, g: 4'h0, b: 4'h4};

  function automatic cells_t block_cells(input shape_t shape, input rot_t rot);
    cells_t c;
    logic [1:0] span;
    logic [1:0] t;
    // rotation 0 layouts
    case (shape)
      shape_o:  c = '{col: {2'd2, 2'd1, 2'd2, 2'd1}, row: {2'd1, 2'd1, 2'd0, 2'd0}};
      shape_t_: c = '{col: {2'd1, 2'd2, 2'd1, 2'd0}, row: {2'd0, 2'd1, 2'd1, 2'd1}};
      shape_s:  c = '{col: {2'd1, 2'd0, 2'd2, 2'd1}, row: {2'd1, 2'd1, 2'd0, 2'd0}};
      shape_z:  c = '{col: {2'd2, 2'd1, 2'd1, 2'd0}, row: {2'd1, 2'd1, 2'd0, 2'd0}};
      shape_j:  c = '{col: {2'd2, 2'd1, 2'd0, 2'd0}, row: {2'd1, 2'd1, 2'd1, 2'd0}};
      shape_l:  c = '{col: {2'd2, 2'd1, 2'd0, 2'd2}, row: {2'd1, 2'd1, 2'd1, 2'd0}};
      default:  c = '{col: {2'd3, 2'd2, 2'd1, 2'd0}, row: {2'd1, 2'd1, 2'd1, 2'd1}};
    endcase
    // quarter turns clockwise, I in a 4x4 box, the rest in 3x3, O fixed
    span = (shape == shape_i) ? 2'd3 : 2'd2;
    for (int k = 0; k < 3; k++) begin
      if (k < int'(rot) && shape != shape_o) begin
        for (int i = 0; i < 4; i++) begin
          t = c.col[i];
          c.col[i] = span - c.row[i];
          c.row[i] = t;
        end
      end
    end
    return c;
  endfunction

  function automatic rgb_t shape_colour(input shape_t shape);
    case (shape)
      shape_i:  return '{r: 4'h0, g: 4'hf, b: 4'hf};
      shape_o:  return '{r: 4'hf, g: 4'hf, b: 4'h0};
      shape_t_: return '{r: 4'ha, g: 4'h0, b: 4'hf};
      shape_s:  return '{r: 4'h0, g: 4'hf, b: 4'h0};
      shape_z:  return '{r: 4'hf, g: 4'h0, b: 4'h0};
      shape_j:  return '{r: 4'h3, g: 4'h5, b: 4'hf};
      default:  return '{r: 4'hf, g: 4'h8, b: 4'h0};
    endcase
  endfunction

endpackage

/* vga_timing.sv */
// ----------------------------------------------------------------------
// vga_timing
// free-running horizontal and vertical counters with registered
// sync and blank decodes
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module vga_timing #(
  parameter int h_active = 800,
  parameter int h_fp     = 40,
  parameter int h_sync   = 128,
  parameter int h_bp     = 88,
  parameter int v_active = 600,
  parameter int v_fp     = 1,
  parameter int v_sync   = 4,
  parameter int v_bp     = 23
) (
  input  logic      pclk,
  input  logic      reset,
  vga_bus_if.src    vout
);
  import vga_pkg::*;

  localparam int h_total = h_active + h_fp + h_sync + h_bp;
  localparam int v_total = v_active + v_fp + v_sync + v_bp;

  logic [cnt_w-1:0] h_next;
  logic [cnt_w-1:0] v_next;
  logic             h_wrap;

  assign h_wrap = (vout.hcount == cnt_w'(h_total - 1));

  always_comb begin
    h_next = h_wrap ? '0 : vout.hcount + 1'b1;
    v_next = vout.vcount;
    if (h_wrap) begin
      v_next = (vout.vcount == cnt_w'(v_total - 1)) ? '0 : vout.vcount + 1'b1;
    end
  end

  // decode from the next count so flags line up with the counters
  always_ff @(posedge pclk) begin
    if (reset) begin
      vout.hcount <= '0;
      vout.vcount <= '0;
      vout.hsync  <= 1'b0;
      vout.vsync  <= 1'b0;
      vout.hblnk  <= 1'b0;
      vout.vblnk  <= 1'b0;
    end else begin
      vout.hcount <= h_next;
      vout.vcount <= v_next;
      vout.hsync  <= (h_next >= cnt_w'(h_active + h_fp)) &&
                     (h_next <  cnt_w'(h_active + h_fp + h_sync));
      vout.vsync  <= (v_next >= cnt_w'(v_active + v_fp)) &&
                     (v_next <  cnt_w'(v_active + v_fp + v_sync));
      vout.hblnk  <= (h_next >= cnt_w'(h_active));
      vout.vblnk  <= (v_next >= cnt_w'(v_active));
    end
  end

  // colour starts at the next stage
  assign vout.rgb = '0;

endmodule

/* vga_top.sv */
// ----------------------------------------------------------------------
// vga_top
// falling-block display: timing, background, piece overlay and the
// registered VGA output
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module vga_top #(
  parameter int h_active  = 800,
  parameter int h_fp      = 40,
  parameter int h_sync    = 128,
  parameter int h_bp      = 88,
  parameter int v_active  = 600,
  parameter int v_fp      = 1,
  parameter int v_sync    = 4,
  parameter int v_bp      = 23,
  parameter int cell_px   = 32,
  parameter int grid_cols = 10,
  parameter int grid_rows = 18
) (
  input  logic       pclk,
  input  logic       reset,
  input  logic       btn_left,
  input  logic       btn_right,
  input  logic       btn_down,
  input  logic       btn_up,
  output logic       hs,
  output logic       vs,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);
  import vga_pkg::*;

  logic [cell_w-1:0] xpos;
  logic [cell_w-1:0] ypos;
  shape_t            shape;
  rot_t              rot;

  vga_bus_if bus_tim ();
  vga_bus_if bus_bg ();
  vga_bus_if bus_blk ();

  vga_timing #(
    .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
    .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
  ) timing_i (
    .pclk  (pclk),
    .reset (reset),
    .vout  (bus_tim)
  );

  draw_background #(
    .h_active(h_active), .v_active(v_active), .cell_px(cell_px),
    .grid_cols(grid_cols), .grid_rows(grid_rows)
  ) background_i (
    .pclk  (pclk),
    .reset (reset),
    .vin   (bus_tim),
    .vout  (bus_bg)
  );

  draw_block #(
    .cell_px(cell_px)
  ) block_i (
    .pclk  (pclk),
    .reset (reset),
    .vin   (bus_bg),
    .vout  (bus_blk),
    .xpos  (xpos),
    .ypos  (ypos),
    .shape (shape),
    .rot   (rot)
  );

  block_ctl #(
    .grid_cols(grid_cols), .grid_rows(grid_rows)
  ) ctl_i (
    .pclk      (pclk),
    .reset     (reset),
    .btn_left  (btn_left),
    .btn_right (btn_right),
    .btn_down  (btn_down),
    .btn_up    (btn_up),
    .xpos      (xpos),
    .ypos      (ypos),
    .shape     (shape),
    .rot       (rot)
  );

  // output pins
  always_ff @(posedge pclk) begin
    if (reset) begin
      hs      <= 1'b0;
      vs      <= 1'b0;
      {r,g,b} <= '0;
    end else begin
      hs      <= bus_blk.hsync;
      vs      <= bus_blk.vsync;
      {r,g,b} <= bus_blk.rgb;
    end
  end

endmodule

/* vga_top_chk.sv */
// ----------------------------------------------------------------------
// vga_top_chk
// concurrent checks on syncs, blanking and piece position of vga_top
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module vga_top_chk #(
  parameter int grid_cols = 10,
  parameter int grid_rows = 18
) (
  input logic                       pclk,
  input logic                       reset,
  input logic                       hs,
  input logic                       vs,
  input logic                       blk_hblnk,
  input logic                       blk_vblnk,
  input logic [11:0]                blk_rgb,
  input logic [vga_pkg::cell_w-1:0] xpos,
  input logic [vga_pkg::cell_w-1:0] ypos
);

  // output register clears one edge into reset
  sync_quiet_in_reset: assert property (@(posedge pclk) reset |=> (!hs && !vs))
    else $error("hs or vs high during reset");

  black_in_blanking: assert property (@(posedge pclk) disable iff (reset)
    (blk_hblnk || blk_vblnk) |-> (blk_rgb == 12'h000))
    else $error("colour not black during blanking");

  origin_in_grid: assert property (@(posedge pclk) disable iff (reset)
    (xpos < grid_cols) && (ypos < grid_rows))
    else $error("piece origin outside the grid");

endmodule

/* vga_top_tb.sv */
// ----------------------------------------------------------------------
// vga_top_tb
// random button presses once per frame on a tiny screen, with a
// pixel-exact model checked on every output cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module vga_top_tb;
  import vga_pkg::*;

  localparam int h_active  = 64;
  localparam int h_fp      = 4;
  localparam int h_sync    = 8;
  localparam int h_bp      = 4;
  localparam int v_active  = 48;
  localparam int v_fp      = 2;
  localparam int v_sync    = 2;
  localparam int v_bp      = 2;
  localparam int cell_px   = 4;
  localparam int grid_cols = 10;
  localparam int grid_rows = 8;
  localparam int h_total   = h_active + h_fp + h_sync + h_bp;
  localparam int v_total   = v_active + v_fp + v_sync + v_bp;
  localparam int n_frames  = 40;
  // counters start after the 2 reset edges, pixels arrive 3 edges later
  localparam int first_pixel = 2 + 3;

  logic       pclk;
  logic       reset;
  logic       btn_left;
  logic       btn_right;
  logic       btn_down;
  logic       btn_up;
  logic       hs;
  logic       vs;
  logic [3:0] r;
  logic [3:0] g;
  logic [3:0] b;

  int       errors      = 0;
  int       neg_n       = 0;
  int       out_h       = 0;
  int       out_v       = 0;
  int       piece_x     = grid_cols / 2 - 2;
  int       piece_y     = 0;
  shape_t   piece_shape = shape_i;
  rot_t     piece_rot   = 2'd0;
  bit [6:0] seen        = 7'b0000001;

  tb_clock #(.period(100), .reset_cycles(2)) clock_i (.pclk(pclk), .reset(reset));

  vga_top #(
    .h_active(h_active), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
    .v_active(v_active), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp),
    .cell_px(cell_px), .grid_cols(grid_cols), .grid_rows(grid_rows)
  ) vga_top_i (
    .pclk(pclk), .reset(reset),
    .btn_left(btn_left), .btn_right(btn_right), .btn_down(btn_down), .btn_up(btn_up),
    .hs(hs), .vs(vs), .r(r), .g(g), .b(b)
  );

  bind vga_top vga_top_chk #(.grid_cols(grid_cols), .grid_rows(grid_rows)) chk_i (
    .pclk(pclk), .reset(reset), .hs(hs), .vs(vs),
    .blk_hblnk(bus_blk.hblnk), .blk_vblnk(bus_blk.vblnk), .blk_rgb(bus_blk.rgb),
    .xpos(xpos), .ypos(ypos)
  );

  task automatic check_value(input string name, input logic [11:0] exp, input logic [11:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %03h, actual %03h", name, exp, act);
    end
  endtask

  function automatic bit piece_fits(input shape_t s, input rot_t rt, input int x, input int y);
    cells_t c;
    int     cx;
    int     cy;
    c = block_cells(s, rt);
    for (int i = 0; i < 4; i++) begin
      cx = x + int'(c.col[i]);
      cy = y + int'(c.row[i]);
      if (cx < 0 || cx >= grid_cols || cy < 0 || cy >= grid_rows)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // pick 1 left, 2 right, 3 up, 4..7 down, 0 nothing
  task automatic apply_button(input int pick);
    int   nx;
    int   ny;
    rot_t nr;
    nx = piece_x;
    ny = piece_y;
    nr = piece_rot;
    if (pick != 0) begin
      case (pick)
        1:       nx = piece_x - 1;
        2:       nx = piece_x + 1;
        3:       nr = piece_rot + 2'd1;
        default: ny = piece_y + 1;
      endcase
      if (piece_fits(piece_shape, nr, nx, ny)) begin
        piece_x   = nx;
        piece_y   = ny;
        piece_rot = nr;
      end else if (pick >= 4) begin
        piece_shape = (piece_shape == shape_l) ? shape_i : piece_shape + 3'd1;
        piece_rot   = 2'd0;
        piece_x     = grid_cols / 2 - 2;
        piece_y     = 0;
        seen[piece_shape] = 1'b1;
      end
    end
  endtask

  task automatic check_pixel();
    cells_t c;
    rgb_t   exp_rgb;
    logic   exp_hs;
    logic   exp_vs;
    bit     hit;
    string  what;
    exp_hs = (out_h >= h_active + h_fp) && (out_h < h_active + h_fp + h_sync);
    exp_vs = (out_v >= v_active + v_fp) && (out_v < v_active + v_fp + v_sync);
    c   = block_cells(piece_shape, piece_rot);
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (out_h / cell_px == piece_x + int'(c.col[i]) &&
          out_v / cell_px == piece_y + int'(c.row[i]))
        hit = 1'b1;
    end
    if (out_h >= h_active || out_v >= v_active) begin
      exp_rgb = '0;
      what    = "blanking";
    end else if (hit) begin
      exp_rgb = shape_colour(piece_shape);
      what    = "piece";
    end else begin
      exp_rgb = (out_h < grid_cols * cell_px && out_v < grid_rows * cell_px) ?
                colour_field : colour_margin;
      what    = "background";
    end
    check_value($sformatf("hsync at %0d,%0d", out_h, out_v), {11'b0, exp_hs}, {11'b0, hs});
    check_value($sformatf("vsync at %0d,%0d", out_h, out_v), {11'b0, exp_vs}, {11'b0, vs});
    check_value($sformatf("%s at %0d,%0d", what, out_h, out_v), exp_rgb, {r, g, b});
  endtask

  // outputs are compared on the falling edge, where they are stable
  always @(negedge pclk) begin
    neg_n++;
    if (neg_n < first_pixel) begin
      check_value("reset outputs", 12'h000, {r, g, b});
      check_value("reset syncs", 12'h000, {10'b0, hs, vs});
    end else begin
      check_pixel();
      out_h++;
      if (out_h == h_total) begin
        out_h = 0;
        out_v = (out_v == v_total - 1) ? 0 : out_v + 1;
      end
    end
  end

  task automatic wait_reset_release(output bit ok);
    int n;
    n = 0;
    @(posedge pclk);
    while (reset && n < 20) begin
      @(posedge pclk);
      n++;
    end
    ok = !reset;
    if (!ok)
      $display("ERROR: timeout waiting for reset release");
  endtask

  // first line of vertical blanking as seen at the outputs
  task automatic wait_output_vblank(output bit ok);
    int n;
    n = 0;
    @(posedge pclk);
    while (!(neg_n >= first_pixel && out_v == v_active && out_h == 0) &&
           n < 2 * h_total * v_total) begin
      @(posedge pclk);
      n++;
    end
    ok = (n < 2 * h_total * v_total);
    if (!ok)
      $display("ERROR: timeout waiting for vertical blanking");
  endtask

  task automatic press_button(input int pick);
    case (pick)
      0:       ;
      1:       btn_left  <= 1'b1;
      2:       btn_right <= 1'b1;
      3:       btn_up    <= 1'b1;
      default: btn_down  <= 1'b1;
    endcase
    apply_button(pick);
    repeat (4) @(posedge pclk);
    btn_left  <= 1'b0;
    btn_right <= 1'b0;
    btn_down  <= 1'b0;
    btn_up    <= 1'b0;
  endtask

  initial begin
    bit ok;
    int pick;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_down  = 1'b0;
    btn_up    = 1'b0;
    void'($urandom(32'h9460));
    wait_reset_release(ok);
    for (int frame = 0; frame < n_frames && ok; frame++) begin
      wait_output_vblank(ok);
      if (ok) begin
        // down weighted so pieces land within the run
        pick = $urandom % 8;
        press_button(pick);
      end
    end
    if (!ok)
      errors++;
    if (ok && $countones(seen) < 2) begin
      errors++;
      $display("ERROR: no piece landed, only one shape was seen");
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
